// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and address width
`define XLEN 32

// register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// memory depths in words
`define IMEM_WORDS 32
`define DMEM_WORDS 32

// word index width, shared by both memories
`define MEM_ADDR_W 5

`endif

// File: cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        SLL = 4'd6,
        SRL = 4'd7,
        SRA = 4'd8
    } alu_op_t;

    // writeback source
    typedef enum logic [1:0] {
        RESULT_ALU = 2'd0,
        RESULT_MEM = 2'd1,
        RESULT_IMM = 2'd2
    } result_sel_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        alu_op_t                alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic                   mem_write;
        result_sel_t            result_sel;
    } ctrl_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } load_t;

    // one record per executed instruction
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       instr;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rd_value;
        logic                   mem_write;
        logic [`XLEN-1:0]       mem_addr;
        logic [`XLEN-1:0]       mem_data;
    } retire_t;

endpackage

`default_nettype wire

// File: instruction_memory.sv
`default_nettype none

`include "cpu_params.svh"

module instruction_memory
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             load_req,
    input  load_t            load,
    output logic             load_ack,
    input  logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] instr
);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];
    logic             load_start;

    // new request seen while ack still low
    assign load_start = load_req && !load_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_ack <= 1'b0;
        end else if (load_start) begin
            load_ack <= 1'b1;
        end else if (!load_req) begin
            load_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && load_start) begin
            mem[load.addr] <= load.data;
        end
    end

    // word fetch, byte offset ignored
    assign instr = mem[pc[`MEM_ADDR_W+1:2]];

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(load_ack) |-> $past(load_req));

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none

`include "cpu_params.svh"

module decoder
    import cpu_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    output ctrl_t            ctrl
);

    opcode_t          opcode;
    logic [2:0]       funct3;
    logic             funct7_5;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // funct7 bit 5 only selects sub for register ops
    function automatic alu_op_t arith_op(
        input logic [2:0] f3,
        input logic       f7_5,
        input logic       is_reg
    );
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && f7_5) ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b100:  op = XOR;
            3'b101:  op = f7_5 ? SRA : SRL;
            3'b110:  op = OR;
            3'b111:  op = AND;
            default: op = ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl            = '0;
        ctrl.rs1        = instr[19:15];
        ctrl.rs2        = instr[24:20];
        ctrl.rd         = instr[11:7];
        ctrl.alu_op     = ADD;
        ctrl.result_sel = RESULT_ALU;
        case (opcode)
            OP: begin
                ctrl.alu_op    = arith_op(funct3, funct7_5, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                ctrl.imm       = imm_i;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = arith_op(funct3, funct7_5, 1'b0);
                ctrl.reg_write = 1'b1;
            end
            LUI: begin
                ctrl.imm        = imm_u;
                ctrl.reg_write  = 1'b1;
                ctrl.result_sel = RESULT_IMM;
            end
            LOAD: begin
                ctrl.imm        = imm_i;
                ctrl.use_imm    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_sel = RESULT_MEM;
            end
            STORE: begin
                ctrl.imm       = imm_s;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: begin
                // anything else retires as a no-op
                ctrl.reg_write = 1'b0;
                ctrl.mem_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

`include "cpu_params.svh"

module alu
    import cpu_pkg::*;
(
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_t          alu_op,
    output logic [`XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ADD: result = a + b;
            SUB: result = a - b;
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            // signed compare
            SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLL: result = a << shamt;
            SRL: result = a >> shamt;
            SRA: result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

`include "cpu_params.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   write_enable,
    input  logic [`XLEN-1:0]       data_in,
    output logic [`XLEN-1:0]       data_out1,
    output logic [`XLEN-1:0]       data_out2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            // x0 is never written
            regs[rd] <= data_in;
        end
    end

    assign data_out1 = regs[rs1];
    assign data_out2 = regs[rs2];

    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (rs1 == '0 |-> data_out1 == '0) and (rs2 == '0 |-> data_out2 == '0));

endmodule

`default_nettype wire

// File: data_memory.sv
`default_nettype none

`include "cpu_params.svh"

module data_memory
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] address,
    input  logic             write_enable,
    input  logic [`XLEN-1:0] data_in,
    output logic [`XLEN-1:0] data_out
);

    logic [`XLEN-1:0]      mem [`DMEM_WORDS];
    logic [`MEM_ADDR_W-1:0] index;

    // word index, low two bits dropped
    assign index = address[`MEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write_enable) begin
            mem[index] <= data_in;
        end
    end

    assign data_out = mem[index];

endmodule

`default_nettype wire

// File: cpu.sv
`default_nettype none

`include "cpu_params.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    run,
    input  logic    load_req,
    input  load_t   load,
    output logic    load_ack,
    output retire_t retire
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] rs1_value;
    logic [`XLEN-1:0] rs2_value;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] mem_rdata;
    logic [`XLEN-1:0] wb_value;
    logic             reg_we;
    logic             mem_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + `XLEN'(4);
        end
    end

    instruction_memory imem_inst (
        .clk(clk),
        .reset(reset),
        .load_req(load_req),
        .load(load),
        .load_ack(load_ack),
        .pc(pc),
        .instr(instr)
    );

    decoder decoder_inst (
        .instr(instr),
        .ctrl(ctrl)
    );

    // no commit while halted
    assign reg_we = ctrl.reg_write && run;
    assign mem_we = ctrl.mem_write && run;

    register_file register_file_inst (
        .clk(clk),
        .reset(reset),
        .rs1(ctrl.rs1),
        .rs2(ctrl.rs2),
        .rd(ctrl.rd),
        .write_enable(reg_we),
        .data_in(wb_value),
        .data_out1(rs1_value),
        .data_out2(rs2_value)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_value;

    alu alu_inst (
        .a(rs1_value),
        .b(alu_b),
        .alu_op(ctrl.alu_op),
        .result(alu_result)
    );

    data_memory dmem_inst (
        .clk(clk),
        .reset(reset),
        .address(alu_result),
        .write_enable(mem_we),
        .data_in(rs2_value),
        .data_out(mem_rdata)
    );

    always_comb begin
        case (ctrl.result_sel)
            RESULT_MEM: wb_value = mem_rdata;
            RESULT_IMM: wb_value = ctrl.imm;
            default:    wb_value = alu_result;
        endcase
    end

    // retire report for the instruction at pc
    always_comb begin
        retire.valid     = run && !reset;
        retire.pc        = pc;
        retire.instr     = instr;
        retire.reg_write = ctrl.reg_write;
        retire.rd        = ctrl.rd;
        retire.rd_value  = wb_value;
        retire.mem_write = ctrl.mem_write;
        retire.mem_addr  = alu_result;
        retire.mem_data  = rs2_value;
    end

    // program load only while halted
    no_load_while_running: assert property (@(posedge clk) disable iff (reset)
        !(load_req && run));

endmodule

`default_nettype wire

// File: tb_cpu.sv
`default_nettype none

`include "cpu_params.svh"

module tb_cpu
    import cpu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic    clk;
    logic    reset;
    logic    run;
    logic    load_req;
    load_t   load;
    logic    load_ack;
    retire_t retire;

    // shadow model state
    logic [`XLEN-1:0] prog  [`IMEM_WORDS];
    logic [`XLEN-1:0] sregs [`REG_COUNT];
    logic [`XLEN-1:0] smem  [`DMEM_WORDS];
    logic [`XLEN-1:0] words [`IMEM_WORDS];
    logic [`XLEN-1:0] model_pc;
    logic [31:0]      lfsr;
    int               errors;
    int               tests;
    bit               timed_out;

    // expected retire fields
    logic [`XLEN-1:0]       w;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       exp_instr;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic                   exp_reg_write;
    logic                   exp_mem_write;
    logic                   exp_is_load;
    logic [`XLEN-1:0]       exp_value;
    logic [`XLEN-1:0]       exp_addr;
    logic [`XLEN-1:0]       exp_data;

    cpu cpu_inst (
        .clk(clk),
        .reset(reset),
        .run(run),
        .load_req(load_req),
        .load(load),
        .load_ack(load_ack),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // reference ALU straight from the ISA rules
    function automatic logic [31:0] isa_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, LUI};
    endfunction

    always_comb begin
        w             = prog[model_pc[`MEM_ADDR_W+1:2]];
        a             = sregs[w[19:15]];
        exp_instr     = w;
        exp_rd        = w[11:7];
        exp_reg_write = 1'b0;
        exp_mem_write = 1'b0;
        exp_is_load   = 1'b0;
        exp_value     = '0;
        exp_addr      = '0;
        exp_data      = '0;
        case (w[6:0])
            OP: begin
                exp_reg_write = 1'b1;
                exp_value     = isa_result(w[14:12], w[30], a, sregs[w[24:20]]);
            end
            OP_IMM: begin
                exp_reg_write = 1'b1;
                exp_value = isa_result(w[14:12], w[14:12] == 3'd5 && w[30], a,
                                       {{20{w[31]}}, w[31:20]});
            end
            LUI: begin
                exp_reg_write = 1'b1;
                exp_value     = {w[31:12], 12'b0};
            end
            LOAD: begin
                exp_reg_write = 1'b1;
                exp_is_load   = 1'b1;
                exp_addr      = a + {{20{w[31]}}, w[31:20]};
                exp_value     = smem[exp_addr[`MEM_ADDR_W+1:2]];
            end
            STORE: begin
                exp_mem_write = 1'b1;
                exp_addr      = a + {{20{w[31]}}, w[31:25], w[11:7]};
                exp_data      = sregs[w[24:20]];
            end
            default: ;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            model_pc <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                sregs[i] <= '0;
            end
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                smem[i] <= '0;
            end
        end else if (run) begin
            model_pc <= model_pc + 32'd4;
            if (exp_reg_write && exp_rd != '0) begin
                sregs[exp_rd] <= exp_value;
            end
            if (exp_mem_write) begin
                smem[exp_addr[`MEM_ADDR_W+1:2]] <= exp_data;
            end
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    valid_follows_run: assert property (@(posedge clk) retire.valid == (run && !reset))
        else report_error("retire.valid differs from run");
    pc_matches: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.pc == model_pc)
        else report_error("retire.pc wrong");
    instr_matches: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.instr == exp_instr)
        else report_error("retire.instr differs from loaded word");
    write_flags: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.reg_write == exp_reg_write
                         && retire.mem_write == exp_mem_write)
        else report_error("reg_write or mem_write wrong");
    rd_value_matches: assert property (@(posedge clk) disable iff (reset)
        retire.valid && exp_reg_write |-> retire.rd == exp_rd && retire.rd_value == exp_value)
        else report_error("rd or rd_value wrong");
    mem_addr_matches: assert property (@(posedge clk) disable iff (reset)
        retire.valid && (exp_mem_write || exp_is_load) |-> retire.mem_addr == exp_addr)
        else report_error("mem_addr wrong");
    store_data_matches: assert property (@(posedge clk) disable iff (reset)
        retire.valid && exp_mem_write |-> retire.mem_data == exp_data)
        else report_error("store data wrong");
    ack_holds: assert property (@(posedge clk) disable iff (reset)
        load_req && load_ack |=> load_ack)
        else report_error("load_ack dropped while load_req high");
    ack_falls_late: assert property (@(posedge clk) disable iff (reset)
        $fell(load_ack) |-> !$past(load_req))
        else report_error("load_ack fell before load_req");

    task automatic load_word(input int idx, input logic [31:0] data);
        int t;
        if (timed_out) return;
        @(posedge clk);
        #1;
        load_req  = 1'b1;
        load.addr = idx[`MEM_ADDR_W-1:0];
        load.data = data;
        prog[idx] = data;
        for (t = 0; t < TIMEOUT && !load_ack; t++) begin
            @(posedge clk);
            #1;
        end
        if (!load_ack) begin
            note_timeout("load_ack rise");
            return;
        end
        // odd words keep req high while ack is up
        if (idx[0]) begin
            @(posedge clk);
            #1;
        end
        load_req = 1'b0;
        for (t = 0; t < TIMEOUT && load_ack; t++) begin
            @(posedge clk);
            #1;
        end
        if (load_ack) begin
            note_timeout("load_ack fall");
        end
    endtask

    task automatic run_until(input int last, input string name);
        int t;
        if (timed_out) return;
        @(posedge clk);
        #1;
        run = 1'b1;
        for (t = 0; t < TIMEOUT && retire.pc != 32'(last * 4); t++) begin
            @(negedge clk);
        end
        if (retire.pc != 32'(last * 4)) begin
            note_timeout({"retire of last instruction in ", name});
            run = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        run = 1'b0;
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    initial begin
        lfsr      = 32'h36ae;
        errors    = 0;
        tests     = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        load_req  = 1'b0;
        load      = '0;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            prog[i]  = '0;
            words[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!load_ack && !retire.valid)
                else report_error("load_ack or retire.valid high while idle");
        end
        tests++;
        $display("test reset finished, errors so far %0d", errors);

        // x1 random, x2 forced negative
        words[0]  = enc_u(20'(rand_bits(20)), 5'd1);
        words[1]  = enc_i(12'(rand_bits(12)), 5'd1, 3'd0, 5'd1, OP_IMM);
        words[2]  = enc_u({1'b1, 19'(rand_bits(19))}, 5'd2);
        words[3]  = enc_i(12'(rand_bits(12)), 5'd2, 3'd0, 5'd2, OP_IMM);
        words[4]  = enc_i(12'(rand_bits(12)), 5'd1, 3'd7, 5'd3, OP_IMM);
        words[5]  = enc_i(12'(rand_bits(12)), 5'd1, 3'd6, 5'd4, OP_IMM);
        words[6]  = enc_i(12'(rand_bits(12)), 5'd2, 3'd4, 5'd5, OP_IMM);
        words[7]  = enc_i(12'(rand_bits(12)), 5'd2, 3'd2, 5'd6, OP_IMM);
        words[8]  = enc_i({7'b0, 5'(rand_bits(5))}, 5'd1, 3'd1, 5'd7, OP_IMM);
        words[9]  = enc_i({7'b0, 5'(rand_bits(5))}, 5'd2, 3'd5, 5'd8, OP_IMM);
        words[10] = enc_i({7'b0100000, 5'(rand_bits(5))}, 5'd2, 3'd5, 5'd9, OP_IMM);
        words[11] = enc_r(7'b0, 5'd2, 5'd1, 3'd0, 5'd10);
        words[12] = enc_r(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd11);
        words[13] = enc_r(7'b0, 5'd2, 5'd1, 3'd7, 5'd12);
        words[14] = enc_r(7'b0, 5'd2, 5'd1, 3'd6, 5'd13);
        words[15] = enc_r(7'b0, 5'd2, 5'd1, 3'd4, 5'd14);
        words[16] = enc_r(7'b0, 5'd1, 5'd2, 3'd2, 5'd15);
        words[17] = enc_r(7'b0, 5'd3, 5'd1, 3'd1, 5'd16);
        words[18] = enc_r(7'b0, 5'd3, 5'd2, 3'd5, 5'd17);
        words[19] = enc_r(7'b0100000, 5'd3, 5'd2, 3'd5, 5'd18);
        // base address, then store and load at a negative offset
        words[20] = enc_i(12'd8 + {7'b0, 3'(rand_bits(3)), 2'b0}, 5'd0, 3'd0, 5'd19, OP_IMM);
        words[21] = enc_s(12'hffc, 5'd10, 5'd19);
        words[22] = enc_i(12'hffc, 5'd19, 3'd2, 5'd20, LOAD);
        words[23] = enc_r(7'b0, 5'd0, 5'd20, 3'd0, 5'd21);
        words[24] = enc_i(12'd123, 5'd0, 3'd0, 5'd0, OP_IMM);
        words[25] = enc_r(7'b0, 5'd1, 5'd0, 3'd0, 5'd22);
        words[26] = 32'h0;
        words[27] = enc_r(7'b0, 5'd5, 5'd20, 3'd0, 5'd23);

        for (int i = 0; i < `IMEM_WORDS; i++) begin
            load_word(i, words[i]);
        end
        if (!timed_out) begin
            tests++;
            $display("test program load finished, errors so far %0d", errors);
        end

        run_until(10, "immediate ops");
        run_until(19, "register ops");
        run_until(23, "store and load");
        run_until(27, "x0 and no-op");

        $display("tests run %0d, errors %0d, timeouts %0d", tests, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
cpu_pkg.sv
instruction_memory.sv
decoder.sv
alu.sv
register_file.sv
data_memory.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    -f verilog.f --top-module tb_cpu -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
